// File: design/a2600_input_pkg.sv
// Word layouts follow the host joystick, analog stick and PS/2 mouse formats; status is 32 bits
`default_nettype none

package a2600_input_pkg;

	// ==================================================
	// Host input words
	// ==================================================

	// Joystick word, bit 0 is right
	typedef struct packed {
		logic [1:0] spare;
		logic       sw_dif2;
		logic       sw_dif1;
		logic       sw_color;
		logic       fire2;
		logic       pause;
		logic       select;
		logic       start;
		logic       paddle_btn;
		logic       stick_btn;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// Two's complement axes, centre at zero
	typedef struct packed {
		logic signed [7:0] y;
		logic signed [7:0] x;
	} stick_t;

	// Strobe toggles once per packet
	typedef struct packed {
		logic       strobe;
		logic [7:0] dy;
		logic [7:0] dx;
		logic [1:0] ovf;
		logic       y_sign;
		logic       x_sign;
		logic [1:0] rsvd;
		logic       right;
		logic       left;
	} mouse_pkt_t;

	typedef enum logic [1:0] {
		SRC_PADDLE = 2'd0,
		SRC_STICK  = 2'd1,
		SRC_MOUSE  = 2'd2
	} pad_src_t;

	// Active-low lines into the console core
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire;
		logic fire2;
	} player_t;

	// ==================================================
	// Cartridge mappers and status bits
	// ==================================================

	// Code 10 is not assigned
	typedef enum logic [3:0] {
		MAP_AUTO = 4'd0,
		MAP_F8   = 4'd1,
		MAP_F6   = 4'd2,
		MAP_FE   = 4'd3,
		MAP_E0   = 4'd4,
		MAP_3F   = 4'd5,
		MAP_F4   = 4'd6,
		MAP_P2   = 4'd7,
		MAP_FA   = 4'd8,
		MAP_CV   = 4'd9,
		MAP_UA   = 4'd11,
		MAP_E7   = 4'd12,
		MAP_F0   = 4'd13,
		MAP_B32  = 4'd14
	} mapper_t;

	localparam int STATUS_W  = 32;
	localparam int NUM_PORTS = 4;

	localparam int ST_PAL    = 1;
	localparam int ST_COLOR  = 2;
	localparam int ST_DIF1   = 3;
	localparam int ST_DIF2   = 4;
	localparam int ST_SC_LO  = 9;
	localparam int ST_SC_HI  = 10;
	localparam int ST_INVERT = 11;
	localparam int ST_SWAP   = 15;

	// Extension is three ASCII characters, dot first
	function automatic mapper_t ext_to_mapper(input logic [23:0] ext);
		mapper_t code;
		case (ext)
			".F8": code = MAP_F8;
			".F6": code = MAP_F6;
			".FE": code = MAP_FE;
			".E0": code = MAP_E0;
			".3F": code = MAP_3F;
			".F4": code = MAP_F4;
			".P2": code = MAP_P2;
			".FA": code = MAP_FA;
			".CV": code = MAP_CV;
			".UA": code = MAP_UA;
			".E7": code = MAP_E7;
			".F0": code = MAP_F0;
			".32": code = MAP_B32;
			default: code = MAP_AUTO;
		endcase
		return code;
	endfunction

endpackage

`default_nettype wire

// File: design/paddle_ctl.sv
// Mouse accumulation needs MOUSE_EN and a step limit of at most 127; the position lags input by 2 cycles
`default_nettype none

module paddle_ctl #(
	parameter bit MOUSE_EN             = 1'b0,
	parameter int MOUSE_STEP_LIMIT     = 10,
	parameter int STICK_AXIS_THRESHOLD = 100
) (
	input  wire logic                        clk_sys,
	input  wire logic                        reset,
	input  wire logic                        invert,
	input  wire logic                        stick_btn,
	input  wire logic                        paddle_btn,
	input  wire a2600_input_pkg::stick_t     stick,
	input  wire logic [7:0]                  paddle,
	input  wire a2600_input_pkg::mouse_pkt_t mouse,
	output logic [7:0]                       pos,
	output logic                             btn
);

	import a2600_input_pkg::*;

	localparam logic signed [8:0] STEP_MAX = 9'(MOUSE_STEP_LIMIT);
	localparam logic signed [8:0] STEP_MIN = -STEP_MAX;

	pad_src_t          src;
	logic              xy_sel;
	logic              stb_d;
	logic              stb_toggle;
	logic signed [8:0] acc_x;
	logic signed [8:0] acc_y;
	logic signed [8:0] step_x;
	logic signed [8:0] step_y;
	logic [7:0]        pre_pos;

	// Half the packet delta, limited to the step range
	function automatic logic signed [8:0] clamp_step(input logic sgn, input logic [6:0] mag);
		logic signed [8:0] d;
		d = {sgn, sgn, mag};
		if (d > STEP_MAX)
			return STEP_MAX;
		else if (d < STEP_MIN)
			return STEP_MIN;
		else
			return d;
	endfunction

	function automatic logic signed [8:0] sat_add(input logic signed [8:0] acc,
		input logic signed [8:0] step);
		logic signed [9:0] sum;
		sum = {acc[8], acc} + {step[8], step};
		if (sum < -10'sd128)
			return -9'sd128;
		else if (sum > 10'sd127)
			return 9'sd127;
		else
			return sum[8:0];
	endfunction

	assign step_x     = clamp_step(mouse.x_sign, mouse.dx[7:1]);
	assign step_y     = clamp_step(mouse.y_sign, mouse.dy[7:1]);
	assign stb_toggle = MOUSE_EN && (mouse.strobe != stb_d);

	// ==================================================
	// Source selection and mouse accumulators
	// ==================================================

	always_ff @(posedge clk_sys) begin
		stb_d <= mouse.strobe;
		if (reset) begin
			src    <= SRC_PADDLE;
			xy_sel <= 1'b0;
			acc_x  <= '0;
			acc_y  <= '0;
		end else begin
			if (stb_toggle) begin
				src   <= SRC_MOUSE;
				acc_x <= sat_add(acc_x, step_x);
				acc_y <= sat_add(acc_y, step_y);
			end
			// Paddle button has the last word
			if (stick_btn)
				src <= SRC_STICK;
			if (paddle_btn)
				src <= SRC_PADDLE;

			if (src == SRC_MOUSE) begin
				if (mouse.right)
					xy_sel <= 1'b1;
				if (mouse.left)
					xy_sel <= 1'b0;
			end
			if (src == SRC_STICK) begin
				if (!stick.y[7] && (stick.y > STICK_AXIS_THRESHOLD))
					xy_sel <= 1'b1;
				if (!stick.x[7] && (stick.x > STICK_AXIS_THRESHOLD))
					xy_sel <= 1'b0;
			end
		end
	end

	// ==================================================
	// Position and button outputs
	// ==================================================

	always_ff @(posedge clk_sys) begin
		case (src)
			SRC_STICK: begin
				pre_pos <= xy_sel ? stick.y : stick.x;
				btn     <= stick_btn;
			end
			SRC_MOUSE: begin
				pre_pos <= xy_sel ? acc_y[7:0] : acc_x[7:0];
				btn     <= mouse.left | mouse.right;
			end
			default: begin
				// Paddle centre moves to 0x80
				pre_pos <= {~paddle[7], paddle[6:0]};
				btn     <= paddle_btn;
			end
		endcase
		pos <= invert ? ~pre_pos : pre_pos;
	end

	acc_in_range: assert property (@(posedge clk_sys) disable iff (reset)
		(acc_x >= -9'sd128) && (acc_x <= 9'sd127) && (acc_y >= -9'sd128) && (acc_y <= 9'sd127));

endmodule

`default_nettype wire

// File: design/player_router.sv
// Swap exchanges players 1/2 and paddle ports 1/2 and 3/4; all outputs are registered once
`default_nettype none

module player_router (
	input  wire logic                                          clk_sys,
	input  wire logic                                          reset,
	input  wire logic                                          swap,
	input  wire a2600_input_pkg::joy_t                         joy0,
	input  wire a2600_input_pkg::joy_t                         joy1,
	input  wire logic [a2600_input_pkg::NUM_PORTS-1:0]         joy_start,
	input  wire logic [a2600_input_pkg::NUM_PORTS-1:0]         joy_select,
	input  wire logic [a2600_input_pkg::NUM_PORTS-1:0][7:0]    pos_in,
	input  wire logic [a2600_input_pkg::NUM_PORTS-1:0]         btn_in,
	output a2600_input_pkg::player_t                           p1,
	output a2600_input_pkg::player_t                           p2,
	output logic [a2600_input_pkg::NUM_PORTS-1:0][7:0]         pos_out,
	output logic [a2600_input_pkg::NUM_PORTS-1:0]              btn_n,
	output logic                                               start_n,
	output logic                                               select_n
);

	import a2600_input_pkg::*;

	function automatic player_t to_player(input joy_t j);
		player_t p;
		p.right = ~j.right;
		p.left  = ~j.left;
		p.down  = ~j.down;
		p.up    = ~j.up;
		p.fire  = ~j.fire;
		p.fire2 = ~j.fire2;
		return p;
	endfunction

	// Control lines, released high in reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			p1       <= '1;
			p2       <= '1;
			btn_n    <= '1;
			start_n  <= 1'b1;
			select_n <= 1'b1;
		end else begin
			p1 <= swap ? to_player(joy1) : to_player(joy0);
			p2 <= swap ? to_player(joy0) : to_player(joy1);
			// Port index with bit 0 flipped is the swap partner
			for (int i = 0; i < NUM_PORTS; i++) begin
				btn_n[i] <= ~btn_in[i ^ int'(swap)];
			end
			start_n  <= ~|joy_start;
			select_n <= ~|joy_select;
		end
	end

	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			pos_out[i] <= pos_in[i ^ int'(swap)];
		end
	end

endmodule

`default_nettype wire

// File: design/console_switches.sv
// Switch requests come from pads 0 and 1 only; status_in is meaningful only while status_set is high
`default_nettype none

module console_switches (
	input  wire logic                                              clk_sys,
	input  wire logic                                              reset,
	input  wire a2600_input_pkg::joy_t [a2600_input_pkg::NUM_PORTS-1:0] joy,
	input  wire logic [a2600_input_pkg::STATUS_W-1:0]              status,
	output logic                                                   pause,
	output logic                                                   status_set,
	output logic [a2600_input_pkg::STATUS_W-1:0]                   status_in
);

	import a2600_input_pkg::*;

	logic                pause_btn;
	logic                pause_s1;
	logic                pause_s2;
	logic [2:0]          sw_now;
	logic [2:0]          sw_d;
	logic [2:0]          sw_rise;
	logic [STATUS_W-1:0] flip;

	// ==================================================
	// Pause toggle
	// ==================================================

	always_comb begin
		pause_btn = 1'b0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			pause_btn = pause_btn | joy[i].pause;
		end
	end

	// Two sampling stages, toggle on the rise between them
	always_ff @(posedge clk_sys) begin
		pause_s1 <= pause_btn;
		pause_s2 <= pause_s1;
		if (reset)
			pause <= 1'b0;
		else if (pause_s1 && !pause_s2)
			pause <= ~pause;
	end

	// ==================================================
	// Switch requests to the host
	// ==================================================

	// Bit 0 colour, bit 1 left difficulty, bit 2 right difficulty
	assign sw_now = {joy[0].sw_dif2 | joy[1].sw_dif2,
		joy[0].sw_dif1 | joy[1].sw_dif1,
		joy[0].sw_color | joy[1].sw_color};
	assign sw_rise = sw_now & ~sw_d;

	always_comb begin
		flip           = '0;
		flip[ST_COLOR] = sw_rise[0];
		flip[ST_DIF1]  = sw_rise[1];
		flip[ST_DIF2]  = sw_rise[2];
	end

	always_ff @(posedge clk_sys) begin
		sw_d <= sw_now;
		if (reset)
			status_set <= 1'b0;
		else
			status_set <= |sw_rise;
	end

	always_ff @(posedge clk_sys) begin
		if (|sw_rise)
			status_in <= status ^ flip;
	end

	set_is_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		status_set |=> !status_set);

endmodule

`default_nettype wire

// File: design/mapper_detect.sv
// Codes latch only on a rising download level; a dot in byte 2 marks a short extension
`default_nettype none

module mapper_detect (
	input  wire logic                                 clk_sys,
	input  wire logic                                 reset,
	input  wire logic                                 download,
	input  wire logic [31:0]                          file_ext,
	input  wire logic [a2600_input_pkg::STATUS_W-1:0] status,
	output a2600_input_pkg::mapper_t                  force_bs,
	output logic                                      sc
);

	import a2600_input_pkg::*;

	logic        download_d;
	logic        download_rise;
	logic [23:0] ext;

	assign download_rise = download && !download_d;

	// Short names sit in the low bytes with the dot third from the bottom
	assign ext = (file_ext[23:16] == ".") ? file_ext[23:0] : file_ext[31:8];

	always_ff @(posedge clk_sys) begin
		download_d <= download;
		if (reset) begin
			force_bs <= MAP_AUTO;
			sc       <= 1'b0;
		end else if (download_rise) begin
			force_bs <= ext_to_mapper(ext);
			// SuperChip setting 0 means auto, so look for a trailing S
			if (status[ST_SC_HI:ST_SC_LO] == 2'b00)
				sc <= (file_ext[7:0] == "S");
			else
				sc <= status[ST_SC_HI];
		end
	end

	no_reserved_code: assert property (@(posedge clk_sys) disable iff (reset)
		4'(force_bs) != 4'd10);

endmodule

`default_nettype wire

// File: design/input_frontend.sv
// Single clock domain; only port 0 takes the mouse, and no input has back-pressure
`default_nettype none

module input_frontend #(
	parameter int MOUSE_STEP_LIMIT     = 10,
	parameter int STICK_AXIS_THRESHOLD = 100
) (
	input  wire logic                                                   clk_sys,
	input  wire logic                                                   reset,
	input  wire a2600_input_pkg::joy_t [a2600_input_pkg::NUM_PORTS-1:0]   joy,
	input  wire a2600_input_pkg::stick_t [a2600_input_pkg::NUM_PORTS-1:0] stick,
	input  wire logic [a2600_input_pkg::NUM_PORTS-1:0][7:0]             paddle,
	input  wire a2600_input_pkg::mouse_pkt_t                            mouse,
	input  wire logic [a2600_input_pkg::STATUS_W-1:0]                   status,
	input  wire logic                                                   download,
	input  wire logic [31:0]                                            file_ext,
	output a2600_input_pkg::player_t                                    p1,
	output a2600_input_pkg::player_t                                    p2,
	output logic [a2600_input_pkg::NUM_PORTS-1:0][7:0]                  pos,
	output logic [a2600_input_pkg::NUM_PORTS-1:0]                       btn_n,
	output logic                                                        start_n,
	output logic                                                        select_n,
	output logic                                                        pause,
	output logic                                                        status_set,
	output logic [a2600_input_pkg::STATUS_W-1:0]                        status_in,
	output a2600_input_pkg::mapper_t                                    force_bs,
	output logic                                                        sc
);

	import a2600_input_pkg::*;

	logic [NUM_PORTS-1:0][7:0] pad_pos;
	logic [NUM_PORTS-1:0]      pad_btn;
	logic [NUM_PORTS-1:0]      pad_start;
	logic [NUM_PORTS-1:0]      pad_select;

	// ==================================================
	// Controller ports
	// ==================================================

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		assign pad_start[i]  = joy[i].start;
		assign pad_select[i] = joy[i].select;

		paddle_ctl #(
			.MOUSE_EN             (i == 0),
			.MOUSE_STEP_LIMIT     (MOUSE_STEP_LIMIT),
			.STICK_AXIS_THRESHOLD (STICK_AXIS_THRESHOLD)
		) u_pad (
			.clk_sys    (clk_sys),
			.reset      (reset),
			.invert     (status[ST_INVERT]),
			.stick_btn  (joy[i].stick_btn),
			.paddle_btn (joy[i].paddle_btn),
			.stick      (stick[i]),
			.paddle     (paddle[i]),
			.mouse      (mouse),
			.pos        (pad_pos[i]),
			.btn        (pad_btn[i])
		);
	end

	player_router u_router (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.swap       (status[ST_SWAP]),
		.joy0       (joy[0]),
		.joy1       (joy[1]),
		.joy_start  (pad_start),
		.joy_select (pad_select),
		.pos_in     (pad_pos),
		.btn_in     (pad_btn),
		.p1         (p1),
		.p2         (p2),
		.pos_out    (pos),
		.btn_n      (btn_n),
		.start_n    (start_n),
		.select_n   (select_n)
	);

	// ==================================================
	// Console switches and cartridge type
	// ==================================================

	console_switches u_switches (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.joy        (joy),
		.status     (status),
		.pause      (pause),
		.status_set (status_set),
		.status_in  (status_in)
	);

	mapper_detect u_mapper (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.download (download),
		.file_ext (file_ext),
		.status   (status),
		.force_bs (force_bs),
		.sc       (sc)
	);

endmodule

`default_nettype wire

// File: bench/input_model.svh
// Reference model for the input front end; include inside the testbench after the package import
`ifndef INPUT_MODEL_SVH
`define INPUT_MODEL_SVH

// ==================================================
// Random numbers and mapper table
// ==================================================

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

localparam int NUM_EXT = 13;

// Two characters after the dot and the code each one selects
localparam logic [15:0] EXT_NAME [NUM_EXT] = '{"F8", "F6", "FE", "E0", "3F", "F4", "P2",
	"FA", "CV", "UA", "E7", "F0", "32"};
localparam logic [3:0] EXT_CODE [NUM_EXT] = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7,
	4'd8, 4'd9, 4'd11, 4'd12, 4'd13, 4'd14};

// ==================================================
// Controller port
// ==================================================

// Halved 9-bit delta is clamped to the step limit and added with saturation
function automatic int accumulate_mouse(input int acc, input logic sgn, input logic [7:0] d,
	input int lim);
	int delta;
	int step;
	int sum;
	delta = sgn ? int'(d) - 256 : int'(d);
	step  = delta >>> 1;
	if (step > lim)
		step = lim;
	if (step < -lim)
		step = -lim;
	sum = acc + step;
	if (sum > 127)
		sum = 127;
	if (sum < -128)
		sum = -128;
	return sum;
endfunction

// Axis choice after the inputs are held in one source
function automatic logic select_axis(input pad_src_t src, input logic ysel, input stick_t s,
	input mouse_pkt_t m, input int thr);
	logic y;
	y = ysel;
	if (src == SRC_MOUSE) begin
		if (m.left)
			y = 1'b0;
		else if (m.right)
			y = 1'b1;
	end else if (src == SRC_STICK) begin
		// X wins when both axes pass the threshold
		if (int'(s.x) >= 0 && int'(s.x) > thr)
			y = 1'b0;
		else if (int'(s.y) >= 0 && int'(s.y) > thr)
			y = 1'b1;
	end
	return y;
endfunction

function automatic logic [7:0] position_byte(input pad_src_t src, input logic ysel,
	input logic [7:0] pad, input stick_t s, input int ax, input int ay, input logic inv);
	logic [7:0] b;
	case (src)
		SRC_STICK: b = ysel ? s.y : s.x;
		SRC_MOUSE: b = ysel ? 8'(ay) : 8'(ax);
		default:   b = pad ^ 8'h80;
	endcase
	return inv ? ~b : b;
endfunction

function automatic logic button_level(input pad_src_t src, input logic pbtn, input logic sbtn,
	input mouse_pkt_t m);
	case (src)
		SRC_STICK: return sbtn;
		SRC_MOUSE: return m.left | m.right;
		default:   return pbtn;
	endcase
endfunction

// ==================================================
// Routing, switches and cartridge type
// ==================================================

function automatic player_t player_lines(input joy_t j);
	player_t p;
	p.right = !j.right;
	p.left  = !j.left;
	p.down  = !j.down;
	p.up    = !j.up;
	p.fire  = !j.fire;
	p.fire2 = !j.fire2;
	return p;
endfunction

// Rise bit 0 is colour, bit 1 left difficulty and bit 2 right difficulty
function automatic logic [31:0] switch_flip_mask(input logic [2:0] rise);
	logic [31:0] f;
	f = '0;
	f[ST_COLOR] = rise[0];
	f[ST_DIF1]  = rise[1];
	f[ST_DIF2]  = rise[2];
	return f;
endfunction

function automatic logic [23:0] extension_chars(input logic [31:0] fe);
	return (fe[23:16] == ".") ? fe[23:0] : fe[31:8];
endfunction

function automatic logic [3:0] mapper_code(input logic [23:0] ext);
	logic [3:0] code;
	code = 4'd0;
	for (int k = 0; k < NUM_EXT; k++) begin
		if (ext == {".", EXT_NAME[k]})
			code = EXT_CODE[k];
	end
	return code;
endfunction

function automatic logic superchip_flag(input logic [31:0] st, input logic [31:0] fe);
	if (st[ST_SC_HI:ST_SC_LO] == 2'b00)
		return fe[7:0] == "S";
	return st[ST_SC_HI];
endfunction

`endif

// File: bench/tb_input_frontend.sv
// Inputs change on falling edges and are held eight cycles per check; only port 0 has a mouse
`default_nettype none

module tb_input_frontend;

	import a2600_input_pkg::*;

	`include "input_model.svh"

	localparam int STEP_LIMIT     = 10;
	localparam int AXIS_THRESHOLD = 100;
	localparam int HOLD_CYCLES    = 8;
	localparam int RESET_CYCLES   = 16;
	localparam int N_PADDLE       = 16;
	localparam int N_STICK        = 12;
	localparam int N_MOUSE        = 16;
	localparam int N_SWAP         = 8;
	// One step after reset, 13 for switches and pause, 32 for the mapper table
	localparam int STEPS_TOTAL    = 1 + N_PADDLE + (N_STICK + 1) + (N_MOUSE + 1) + (N_SWAP + 1)
		+ 13 + 32;
	localparam int TIMEOUT_CYCLES = 2 * (STEPS_TOTAL * (HOLD_CYCLES + 1)
		+ 2 * (RESET_CYCLES + 1));

	logic                clk_sys;
	logic                reset;
	joy_t [3:0]          joy;
	stick_t [3:0]        stick;
	logic [3:0][7:0]     paddle;
	mouse_pkt_t          mouse;
	logic [31:0]         status;
	logic                download;
	logic [31:0]         file_ext;
	player_t             p1;
	player_t             p2;
	logic [3:0][7:0]     pos;
	logic [3:0]          btn_n;
	logic                start_n;
	logic                select_n;
	logic                pause;
	logic                status_set;
	logic [31:0]         status_in;
	mapper_t             force_bs;
	logic                sc;

	// Model state and expected outputs
	pad_src_t            m_src [4];
	logic                m_ysel [4];
	int                  m_acc_x;
	int                  m_acc_y;
	logic                m_strobe_d;
	logic [2:0]          m_sw_d;
	logic                m_pause_d;
	logic                m_dl_d;
	logic                m_pause;
	logic [3:0]          m_bs;
	logic                m_sc;
	logic [3:0][7:0]     exp_pos;
	logic [3:0]          exp_btn_n;
	player_t             exp_p1;
	player_t             exp_p2;
	logic                exp_start_n;
	logic                exp_select_n;
	int                  exp_set_count;
	logic [31:0]         exp_status_in;

	logic [31:0]         rng;
	logic                check_req;
	int                  set_count;
	logic [31:0]         last_status_in;
	int                  cycles;
	int                  checks;
	int                  errors;
	int                  test_checks;
	int                  test_errors;

	input_frontend #(
		.MOUSE_STEP_LIMIT     (STEP_LIMIT),
		.STICK_AXIS_THRESHOLD (AXIS_THRESHOLD)
	) dut0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.joy        (joy),
		.stick      (stick),
		.paddle     (paddle),
		.mouse      (mouse),
		.status     (status),
		.download   (download),
		.file_ext   (file_ext),
		.p1         (p1),
		.p2         (p2),
		.pos        (pos),
		.btn_n      (btn_n),
		.start_n    (start_n),
		.select_n   (select_n),
		.pause      (pause),
		.status_set (status_set),
		.status_in  (status_in),
		.force_bs   (force_bs),
		.sc         (sc)
	);

	always #5 clk_sys = ~clk_sys;

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic joy_t random_joy(input logic [31:0] r);
		joy_t j;
		j        = '0;
		j.right  = r[0];
		j.left   = r[1];
		j.down   = r[2];
		j.up     = r[3];
		j.fire   = r[4];
		j.fire2  = r[5];
		j.start  = r[6] & r[8];
		j.select = r[7] & r[9];
		return j;
	endfunction

	// ==================================================
	// Reference model update for held inputs
	// ==================================================

	task automatic update_model();
		logic [3:0][7:0] ppos;
		logic [3:0]      pbtn;
		logic [2:0]      sw;
		logic            pz;
		int              swp;
		pad_src_t        nsrc;
		for (int p = 0; p < 4; p++) begin
			// First cycle still runs under the old source
			m_ysel[p] = select_axis(m_src[p], m_ysel[p], stick[p], mouse, AXIS_THRESHOLD);
			nsrc = m_src[p];
			if (p == 0 && mouse.strobe != m_strobe_d) begin
				nsrc    = SRC_MOUSE;
				m_acc_x = accumulate_mouse(m_acc_x, mouse.x_sign, mouse.dx, STEP_LIMIT);
				m_acc_y = accumulate_mouse(m_acc_y, mouse.y_sign, mouse.dy, STEP_LIMIT);
			end
			if (joy[p].stick_btn)
				nsrc = SRC_STICK;
			if (joy[p].paddle_btn)
				nsrc = SRC_PADDLE;
			m_src[p]  = nsrc;
			m_ysel[p] = select_axis(nsrc, m_ysel[p], stick[p], mouse, AXIS_THRESHOLD);
			ppos[p] = position_byte(nsrc, m_ysel[p], paddle[p], stick[p], m_acc_x, m_acc_y,
				status[ST_INVERT]);
			pbtn[p] = button_level(nsrc, joy[p].paddle_btn, joy[p].stick_btn, mouse);
		end
		m_strobe_d = mouse.strobe;
		swp = int'(status[ST_SWAP]);
		for (int p = 0; p < 4; p++) begin
			exp_pos[p]   = ppos[p ^ swp];
			exp_btn_n[p] = !pbtn[p ^ swp];
		end
		exp_p1 = player_lines(swp == 1 ? joy[1] : joy[0]);
		exp_p2 = player_lines(swp == 1 ? joy[0] : joy[1]);
		exp_start_n  = !(joy[0].start | joy[1].start | joy[2].start | joy[3].start);
		exp_select_n = !(joy[0].select | joy[1].select | joy[2].select | joy[3].select);
		sw = {joy[0].sw_dif2 | joy[1].sw_dif2, joy[0].sw_dif1 | joy[1].sw_dif1,
			joy[0].sw_color | joy[1].sw_color};
		if (|(sw & ~m_sw_d)) begin
			exp_set_count++;
			exp_status_in = status ^ switch_flip_mask(sw & ~m_sw_d);
		end
		m_sw_d = sw;
		pz = joy[0].pause | joy[1].pause | joy[2].pause | joy[3].pause;
		if (pz && !m_pause_d)
			m_pause = !m_pause;
		m_pause_d = pz;
		if (download && !m_dl_d) begin
			m_bs = mapper_code(extension_chars(file_ext));
			m_sc = superchip_flag(status, file_ext);
		end
		m_dl_d = download;
	endtask

	task automatic clear_model();
		for (int p = 0; p < 4; p++) begin
			m_src[p]  = SRC_PADDLE;
			m_ysel[p] = 1'b0;
		end
		m_acc_x = 0;
		m_acc_y = 0;
		m_pause = 1'b0;
		m_bs    = 4'd0;
		m_sc    = 1'b0;
	endtask

	// Starts and returns on a falling edge
	task automatic apply_and_check();
		update_model();
		repeat (HOLD_CYCLES) @(posedge clk_sys);
		check_req = 1'b1;
		wait (check_req == 1'b0);
	endtask

	task automatic pulse_reset();
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		clear_model();
	endtask

	task automatic begin_test();
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
	endtask

	// ==================================================
	// Comparing process
	// ==================================================

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		test_checks++;
		assert (got === exp) else begin
			$display("Error: %0t %s is %h, expected %h", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	always @(negedge clk_sys) begin
		if (status_set === 1'b1) begin
			set_count++;
			last_status_in = status_in;
		end
		if (check_req) begin
			for (int p = 0; p < 4; p++) begin
				compare_value($sformatf("pos[%0d]", p), 32'(pos[p]), 32'(exp_pos[p]));
				compare_value($sformatf("btn_n[%0d]", p), 32'(btn_n[p]), 32'(exp_btn_n[p]));
			end
			compare_value("p1", 32'(p1), 32'(exp_p1));
			compare_value("p2", 32'(p2), 32'(exp_p2));
			compare_value("start_n", 32'(start_n), 32'(exp_start_n));
			compare_value("select_n", 32'(select_n), 32'(exp_select_n));
			compare_value("pause", 32'(pause), 32'(m_pause));
			compare_value("force_bs", 32'(force_bs), 32'(m_bs));
			compare_value("sc", 32'(sc), 32'(m_sc));
			compare_value("status_set pulses", 32'(set_count), 32'(exp_set_count));
			compare_value("status_in", last_status_in, exp_status_in);
			check_req = 1'b0;
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================

	initial begin
		logic [31:0] r;
		clk_sys        = 1'b0;
		reset          = 1'b1;
		joy            = '0;
		stick          = '0;
		paddle         = '0;
		mouse          = '0;
		status         = '0;
		download       = 1'b0;
		file_ext       = '0;
		rng            = 32'hbce5;
		check_req      = 1'b0;
		set_count      = 0;
		last_status_in = '0;
		exp_set_count  = 0;
		exp_status_in  = '0;
		m_strobe_d     = 1'b0;
		m_sw_d         = '0;
		m_pause_d      = 1'b0;
		m_dl_d         = 1'b0;
		cycles         = 0;
		checks         = 0;
		errors         = 0;
		pulse_reset();
		apply_and_check();

		// Paddle mode with invert in the second half
		begin_test();
		for (int k = 0; k < N_PADDLE; k++) begin
			status[ST_INVERT] = (k >= N_PADDLE / 2);
			for (int p = 0; p < 4; p++) begin
				r = next_rand();
				joy[p]            = random_joy(r);
				joy[p].paddle_btn = r[12];
				paddle[p]         = r[23:16];
			end
			apply_and_check();
		end
		status[ST_INVERT] = 1'b0;
		end_test("paddle");

		// Stick mode where every third word pushes Y past the threshold
		begin_test();
		for (int p = 0; p < 4; p++) begin
			joy[p]           = '0;
			joy[p].stick_btn = 1'b1;
		end
		apply_and_check();
		for (int k = 0; k < N_STICK; k++) begin
			for (int p = 0; p < 4; p++) begin
				r = next_rand();
				joy[p]           = random_joy(r);
				joy[p].stick_btn = r[13];
				if (k % 3 == 1) begin
					stick[p].x = {2'b00, r[21:16]};
					stick[p].y = 8'd101 + {4'd0, r[27:24]};
				end else begin
					stick[p] = r[31:16];
				end
			end
			apply_and_check();
		end
		end_test("stick");

		// Mouse on port 0 with X first and Y once the right button is held
		begin_test();
		for (int p = 0; p < 4; p++)
			joy[p] = '0;
		for (int k = 0; k < N_MOUSE; k++) begin
			r = next_rand();
			mouse.strobe = !mouse.strobe;
			mouse.x_sign = (k >= 14);
			mouse.dx     = (k >= 14) ? r[7:0] : (r[7:0] | 8'h40);
			mouse.y_sign = r[16];
			mouse.dy     = r[15:8];
			mouse.left   = (k < 10) ? r[17] : 1'b0;
			mouse.right  = (k >= 10);
			apply_and_check();
		end
		mouse.left        = 1'b0;
		mouse.right       = 1'b0;
		joy[0].paddle_btn = 1'b1;
		apply_and_check();
		end_test("mouse");

		// Player and port swap
		begin_test();
		for (int p = 0; p < 4; p++) begin
			joy[p].paddle_btn = 1'b1;
			paddle[p]         = 8'(next_rand() >> 24);
		end
		apply_and_check();
		for (int k = 0; k < N_SWAP; k++) begin
			status[ST_SWAP] = k[0];
			for (int p = 0; p < 4; p++) begin
				r = next_rand();
				joy[p]            = random_joy(r);
				joy[p].paddle_btn = r[12];
				paddle[p]         = r[23:16];
			end
			apply_and_check();
		end
		status[ST_SWAP] = 1'b0;
		end_test("swap");

		// Switch requests followed by three pause presses and a reset
		begin_test();
		status = next_rand() & 32'hffff_71ff;
		joy    = '0;
		for (int b = 0; b < 3; b++) begin
			case (b)
				0: joy[b % 2].sw_color = 1'b1;
				1: joy[b % 2].sw_dif1  = 1'b1;
				default: joy[b % 2].sw_dif2 = 1'b1;
			endcase
			apply_and_check();
			joy = '0;
			apply_and_check();
		end
		for (int k = 0; k < 3; k++) begin
			joy[k].pause = 1'b1;
			apply_and_check();
			joy[k].pause = 1'b0;
			apply_and_check();
		end
		pulse_reset();
		apply_and_check();
		end_test("switches");

		// Mapper table in alternating dotted and four-character forms
		begin_test();
		status = '0;
		for (int k = 0; k < NUM_EXT; k++) begin
			r = next_rand();
			if (k % 2 == 0)
				file_ext = {8'h41 + {4'd0, r[3:0]}, ".", EXT_NAME[k]};
			else
				file_ext = {".", EXT_NAME[k], "S"};
			download = 1'b1;
			apply_and_check();
			download = 1'b0;
			apply_and_check();
		end
		for (int k = 0; k < 3; k++) begin
			case (k)
				0: file_ext = "A.ZZ";
				1: file_ext = "A.F6";
				default: file_ext = ".E0S";
			endcase
			status[ST_SC_HI:ST_SC_LO] = (k == 0) ? 2'b00 : ((k == 1) ? 2'b10 : 2'b01);
			download = 1'b1;
			apply_and_check();
			download = 1'b0;
			apply_and_check();
		end
		end_test("mapper");

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+bench
design/a2600_input_pkg.sv
design/paddle_ctl.sv
design/player_router.sv
design/console_switches.sv
design/mapper_detect.sv
design/input_frontend.sv
bench/tb_input_frontend.sv

// File: Makefile
# Verilator build and run for the input front end testbench

VERILATOR ?= verilator
TOP       ?= tb_input_frontend
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard design/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
